// File: hdl/avmm_rdwr_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths, response codes and payload
// structs shared by the split read/write
// Avalon memory channel
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package avmm_rdwr_pkg;

    // Word address, data and byte enable widths of both channels
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // Only the low part of the address space is backed by storage
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_WIDTH = $clog2(MEM_WORDS);

    // Avalon response encoding, only the codes this memory returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } avmm_resp_t;

    // Read request, one word per request
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [BE_WIDTH-1:0]   byteenable;
    } rd_req_t;

    // Write request carries its data along with the address
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] address;
        logic [DATA_WIDTH-1:0] writedata;
        logic [BE_WIDTH-1:0]   byteenable;
    } wr_req_t;

    // Read response, data plus status
    typedef struct packed {
        logic [DATA_WIDTH-1:0] readdata;
        avmm_resp_t            response;
    } rd_rsp_t;

    // Write response is status only
    typedef struct packed {
        avmm_resp_t response;
    } wr_rsp_t;

endpackage

`default_nettype wire

// File: hdl/avmm_wait_bridge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One registered stage for a single
// Avalon channel, with a one-entry skid
// buffer and a registered response path
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module avmm_wait_bridge
  #(
    // Request and response payloads of the channel this stage carries
    parameter type req_t = logic,
    parameter type rsp_t = logic
    )
   (
    input  wire   clk,
    input  wire   reset,

    // Upstream side facing the host
    input  wire   up_req,
    input  req_t  up_payload,
    output logic  up_waitrequest,
    output logic  up_rspvalid,
    output rsp_t  up_rsp,

    // Downstream side facing the memory
    output logic  dn_req,
    output req_t  dn_payload,
    input  wire   dn_waitrequest,
    input  wire   dn_rspvalid,
    input  rsp_t  dn_rsp
    );

    // Skid entry holds the one request that arrives while the output is stalled
    logic skid_valid;
    req_t skid_payload;

    logic up_accept;
    logic dn_stall;
    logic out_load;

    // Upstream waitrequest comes straight from a flop, so nothing
    // combinational crosses the stage
    assign up_waitrequest = skid_valid;

    // A request is taken from upstream only while the skid is empty
    assign up_accept = up_req && !skid_valid;

    // The output register is stuck while the downstream side holds it off
    assign dn_stall = dn_req && dn_waitrequest;

    // Output register may take a new value whenever it is empty or being consumed
    assign out_load = !dn_stall;

    // Control state of the request path
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dn_req <= 1'b0;
            skid_valid <= 1'b0;
        end
        else
        begin
            if (out_load)
            begin
                // The skid drains first so request order is kept
                dn_req <= skid_valid || up_accept;
            end

            if (skid_valid)
            begin
                // Skid stays full until the output register frees up
                skid_valid <= dn_stall;
            end
            else
            begin
                skid_valid <= up_accept && dn_stall;
            end
        end
    end

    // Request payloads are loaded alongside the control bits above
    always_ff @(posedge clk)
    begin
        if (out_load)
        begin
            dn_payload <= skid_valid ? skid_payload : up_payload;
        end

        // Only reached when the skid is empty, since up_accept needs that
        if (up_accept && dn_stall)
        begin
            skid_payload <= up_payload;
        end
    end

    // Responses have no back-pressure, so one register per stage is enough
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            up_rspvalid <= 1'b0;
        end
        else
        begin
            up_rspvalid <= dn_rspvalid;
        end
    end

    always_ff @(posedge clk)
    begin
        up_rsp <= dn_rsp;
    end

    // A stalled request must stay on the bus unchanged until the receiver takes it
    assert property (@(posedge clk) disable iff (reset)
                     dn_req && dn_waitrequest |=> dn_req && $stable(dn_payload))
        else $error("avmm_wait_bridge: stalled downstream request changed");

    // A full skid under stall keeps its entry, so no request is lost
    assert property (@(posedge clk) disable iff (reset)
                     skid_valid && dn_stall |=> skid_valid && $stable(skid_payload))
        else $error("avmm_wait_bridge: skid entry lost while stalled");

endmodule

`default_nettype wire

// File: hdl/avmm_rdwr_reg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Configurable chain of register stages
// between the host side and the memory
// side of a split read/write channel
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module avmm_rdwr_reg
  import avmm_rdwr_pkg::*;
  #(
    // Number of bridge stages, zero gives plain wires
    parameter int N_REG_STAGES = 1
    )
   (
    input  wire      clk,
    input  wire      reset,

    // Host side
    input  wire      host_rd_read,
    input  rd_req_t  host_rd_req,
    output logic     host_rd_waitrequest,
    output logic     host_rd_readdatavalid,
    output rd_rsp_t  host_rd_rsp,
    input  wire      host_wr_write,
    input  wr_req_t  host_wr_req,
    output logic     host_wr_waitrequest,
    output logic     host_wr_writeresponsevalid,
    output wr_rsp_t  host_wr_rsp,

    // Memory side
    output logic     mem_rd_read,
    output rd_req_t  mem_rd_req,
    input  wire      mem_rd_waitrequest,
    input  wire      mem_rd_readdatavalid,
    input  rd_rsp_t  mem_rd_rsp,
    output logic     mem_wr_write,
    output wr_req_t  mem_wr_req,
    input  wire      mem_wr_waitrequest,
    input  wire      mem_wr_writeresponsevalid,
    input  wr_rsp_t  mem_wr_rsp
    );

    genvar s;
    generate
        if (N_REG_STAGES == 0)
        begin : wires
            // No stages, the two sides are connected directly
            assign mem_rd_read = host_rd_read;
            assign mem_rd_req = host_rd_req;
            assign host_rd_waitrequest = mem_rd_waitrequest;
            assign host_rd_readdatavalid = mem_rd_readdatavalid;
            assign host_rd_rsp = mem_rd_rsp;
            assign mem_wr_write = host_wr_write;
            assign mem_wr_req = host_wr_req;
            assign host_wr_waitrequest = mem_wr_waitrequest;
            assign host_wr_writeresponsevalid = mem_wr_writeresponsevalid;
            assign host_wr_rsp = mem_wr_rsp;
        end
        else
        begin : regs
            // Entry 0 is the host side and entry N_REG_STAGES the memory side
            logic    rd_read [N_REG_STAGES+1];
            rd_req_t rd_req [N_REG_STAGES+1];
            logic    rd_waitrequest [N_REG_STAGES+1];
            logic    rd_readdatavalid [N_REG_STAGES+1];
            rd_rsp_t rd_rsp [N_REG_STAGES+1];
            logic    wr_write [N_REG_STAGES+1];
            wr_req_t wr_req [N_REG_STAGES+1];
            logic    wr_waitrequest [N_REG_STAGES+1];
            logic    wr_writeresponsevalid [N_REG_STAGES+1];
            wr_rsp_t wr_rsp [N_REG_STAGES+1];

            // Host ports map onto entry 0 so the loop below is uniform
            assign rd_read[0] = host_rd_read;
            assign rd_req[0] = host_rd_req;
            assign host_rd_waitrequest = rd_waitrequest[0];
            assign host_rd_readdatavalid = rd_readdatavalid[0];
            assign host_rd_rsp = rd_rsp[0];
            assign wr_write[0] = host_wr_write;
            assign wr_req[0] = host_wr_req;
            assign host_wr_waitrequest = wr_waitrequest[0];
            assign host_wr_writeresponsevalid = wr_writeresponsevalid[0];
            assign host_wr_rsp = wr_rsp[0];

            for (s = 1; s <= N_REG_STAGES; s = s + 1)
            begin : p
                // Read channel stage
                avmm_wait_bridge
                  #(
                    .req_t(rd_req_t),
                    .rsp_t(rd_rsp_t)
                    )
                  bridge_rd
                   (
                    .clk(clk),
                    .reset(reset),
                    .up_req(rd_read[s-1]),
                    .up_payload(rd_req[s-1]),
                    .up_waitrequest(rd_waitrequest[s-1]),
                    .up_rspvalid(rd_readdatavalid[s-1]),
                    .up_rsp(rd_rsp[s-1]),
                    .dn_req(rd_read[s]),
                    .dn_payload(rd_req[s]),
                    .dn_waitrequest(rd_waitrequest[s]),
                    .dn_rspvalid(rd_readdatavalid[s]),
                    .dn_rsp(rd_rsp[s])
                    );

                // Write channel stage, same bridge with the write payloads
                avmm_wait_bridge
                  #(
                    .req_t(wr_req_t),
                    .rsp_t(wr_rsp_t)
                    )
                  bridge_wr
                   (
                    .clk(clk),
                    .reset(reset),
                    .up_req(wr_write[s-1]),
                    .up_payload(wr_req[s-1]),
                    .up_waitrequest(wr_waitrequest[s-1]),
                    .up_rspvalid(wr_writeresponsevalid[s-1]),
                    .up_rsp(wr_rsp[s-1]),
                    .dn_req(wr_write[s]),
                    .dn_payload(wr_req[s]),
                    .dn_waitrequest(wr_waitrequest[s]),
                    .dn_rspvalid(wr_writeresponsevalid[s]),
                    .dn_rsp(wr_rsp[s])
                    );
            end

            // Last entry is the memory side
            assign mem_rd_read = rd_read[N_REG_STAGES];
            assign mem_rd_req = rd_req[N_REG_STAGES];
            assign rd_waitrequest[N_REG_STAGES] = mem_rd_waitrequest;
            assign rd_readdatavalid[N_REG_STAGES] = mem_rd_readdatavalid;
            assign rd_rsp[N_REG_STAGES] = mem_rd_rsp;
            assign mem_wr_write = wr_write[N_REG_STAGES];
            assign mem_wr_req = wr_req[N_REG_STAGES];
            assign wr_waitrequest[N_REG_STAGES] = mem_wr_waitrequest;
            assign wr_writeresponsevalid[N_REG_STAGES] = mem_wr_writeresponsevalid;
            assign wr_rsp[N_REG_STAGES] = mem_wr_rsp;
        end
    endgenerate

endmodule

`default_nettype wire

// File: hdl/avmm_rdwr_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word memory behind split read and
// write channels, with write priority,
// byte enables and error responses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module avmm_rdwr_mem
  import avmm_rdwr_pkg::*;
   (
    input  wire      clk,
    input  wire      reset,

    // Read channel
    input  wire      rd_read,
    input  rd_req_t  rd_req,
    output logic     rd_waitrequest,
    output logic     rd_readdatavalid,
    output rd_rsp_t  rd_rsp,

    // Write channel
    input  wire      wr_write,
    input  wr_req_t  wr_req,
    output logic     wr_waitrequest,
    output logic     wr_writeresponsevalid,
    output wr_rsp_t  wr_rsp
    );

    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic rd_accept;
    logic wr_accept;
    logic rd_in_range;
    logic wr_in_range;
    logic [MEM_IDX_WIDTH-1:0] rd_idx;
    logic [MEM_IDX_WIDTH-1:0] wr_idx;

    // The memory has a single port, so a write blocks a read in the same cycle
    assign wr_waitrequest = 1'b0;
    assign rd_waitrequest = rd_read && wr_write;

    assign wr_accept = wr_write;
    assign rd_accept = rd_read && !rd_waitrequest;

    // Anything at or above MEM_WORDS has no storage behind it
    assign rd_in_range = (rd_req.address < ADDR_WIDTH'(MEM_WORDS));
    assign wr_in_range = (wr_req.address < ADDR_WIDTH'(MEM_WORDS));

    assign rd_idx = rd_req.address[MEM_IDX_WIDTH-1:0];
    assign wr_idx = wr_req.address[MEM_IDX_WIDTH-1:0];

    // Storage, only bytes with their enable set are written
    always_ff @(posedge clk)
    begin
        if (wr_accept && wr_in_range)
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (wr_req.byteenable[b])
                begin
                    mem[wr_idx][8*b +: 8] <= wr_req.writedata[8*b +: 8];
                end
            end
        end
    end

    // Response valids, one cycle after acceptance
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_readdatavalid <= 1'b0;
            wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            rd_readdatavalid <= rd_accept;
            wr_writeresponsevalid <= wr_accept;
        end
    end

    // Response payloads, an out-of-range read returns zero with an error
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            if (rd_in_range)
            begin
                rd_rsp.readdata <= mem[rd_idx];
                rd_rsp.response <= RESP_OKAY;
            end
            else
            begin
                rd_rsp.readdata <= '0;
                rd_rsp.response <= RESP_SLVERR;
            end
        end

        if (wr_accept)
        begin
            wr_rsp.response <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // A read held off by a write produces no data on the following cycle
    assert property (@(posedge clk) disable iff (reset)
                     rd_read && rd_waitrequest |=> !rd_readdatavalid)
        else $error("avmm_rdwr_mem: read data returned for a stalled read");

endmodule

`default_nettype wire

// File: hdl/avmm_rdwr_mem_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level with the register pipeline
// in front of the word memory
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module avmm_rdwr_mem_top
  import avmm_rdwr_pkg::*;
  #(
    parameter int N_REG_STAGES = 2
    )
   (
    input  wire      clk,
    input  wire      reset,

    // Host read channel
    input  wire      host_rd_read,
    input  rd_req_t  host_rd_req,
    output logic     host_rd_waitrequest,
    output logic     host_rd_readdatavalid,
    output rd_rsp_t  host_rd_rsp,

    // Host write channel
    input  wire      host_wr_write,
    input  wr_req_t  host_wr_req,
    output logic     host_wr_waitrequest,
    output logic     host_wr_writeresponsevalid,
    output wr_rsp_t  host_wr_rsp
    );

    // Channel between the last stage and the memory
    logic    mem_rd_read;
    rd_req_t mem_rd_req;
    logic    mem_rd_waitrequest;
    logic    mem_rd_readdatavalid;
    rd_rsp_t mem_rd_rsp;
    logic    mem_wr_write;
    wr_req_t mem_wr_req;
    logic    mem_wr_waitrequest;
    logic    mem_wr_writeresponsevalid;
    wr_rsp_t mem_wr_rsp;

    // Each stage adds a cycle in each direction
    avmm_rdwr_reg
      #(
        .N_REG_STAGES(N_REG_STAGES)
        )
      pipe
       (
        .clk,
        .reset,
        .host_rd_read,
        .host_rd_req,
        .host_rd_waitrequest,
        .host_rd_readdatavalid,
        .host_rd_rsp,
        .host_wr_write,
        .host_wr_req,
        .host_wr_waitrequest,
        .host_wr_writeresponsevalid,
        .host_wr_rsp,
        .mem_rd_read,
        .mem_rd_req,
        .mem_rd_waitrequest,
        .mem_rd_readdatavalid,
        .mem_rd_rsp,
        .mem_wr_write,
        .mem_wr_req,
        .mem_wr_waitrequest,
        .mem_wr_writeresponsevalid,
        .mem_wr_rsp
        );

    avmm_rdwr_mem
      mem
       (
        .clk,
        .reset,
        .rd_read(mem_rd_read),
        .rd_req(mem_rd_req),
        .rd_waitrequest(mem_rd_waitrequest),
        .rd_readdatavalid(mem_rd_readdatavalid),
        .rd_rsp(mem_rd_rsp),
        .wr_write(mem_wr_write),
        .wr_req(mem_wr_req),
        .wr_waitrequest(mem_wr_waitrequest),
        .wr_writeresponsevalid(mem_wr_writeresponsevalid),
        .wr_rsp(mem_wr_rsp)
        );

endmodule

`default_nettype wire

// File: sim/avmm_rdwr_mem_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the pipelined memory:
// directed table, same-cycle collision,
// back-to-back reads, random rounds
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module avmm_rdwr_mem_tb
  import avmm_rdwr_pkg::*;
  ();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int N_DIR = 15;
    localparam int N_ROUNDS = 8;
    localparam int ROUND_LEN = 12;
    localparam int BANK_WORDS = 16;

    // One directed step, expected values worked out by hand from the byte-enable rule
    typedef struct packed {
        logic                  is_write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [BE_WIDTH-1:0]   be;
        logic [DATA_WIDTH-1:0] exp_data;
        avmm_resp_t            exp_resp;
    } dir_entry_t;

    logic    clk;
    logic    reset;
    logic    host_rd_read;
    rd_req_t host_rd_req;
    logic    host_rd_waitrequest;
    logic    host_rd_readdatavalid;
    rd_rsp_t host_rd_rsp;
    logic    host_wr_write;
    wr_req_t host_wr_req;
    logic    host_wr_waitrequest;
    logic    host_wr_writeresponsevalid;
    wr_rsp_t host_wr_rsp;

    dir_entry_t dir_table [N_DIR];

    // Expected memory contents and the responses still owed, in request order
    logic [DATA_WIDTH-1:0] shadow [MEM_WORDS];
    logic [DATA_WIDTH-1:0] exp_rd_data [$];
    avmm_resp_t            exp_rd_resp [$];
    avmm_resp_t            exp_wr_resp [$];
    logic [DATA_WIDTH-1:0] want_data;
    avmm_resp_t            want_resp;

    integer seed = 32'hfef4;
    int rd_issued = 0;
    int wr_issued = 0;
    int rd_accepted = 0;
    int wr_accepted = 0;
    int rd_responses = 0;
    int wr_responses = 0;
    int data_errors = 0;
    int resp_errors = 0;
    int proto_errors = 0;

    avmm_rdwr_mem_top
      #(
        .N_REG_STAGES(2)
        )
      DUT
       (
        .clk(clk),
        .reset(reset),
        .host_rd_read(host_rd_read),
        .host_rd_req(host_rd_req),
        .host_rd_waitrequest(host_rd_waitrequest),
        .host_rd_readdatavalid(host_rd_readdatavalid),
        .host_rd_rsp(host_rd_rsp),
        .host_wr_write(host_wr_write),
        .host_wr_req(host_wr_req),
        .host_wr_waitrequest(host_wr_waitrequest),
        .host_wr_writeresponsevalid(host_wr_writeresponsevalid),
        .host_wr_rsp(host_wr_rsp)
        );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic addr_in_range(input logic [ADDR_WIDTH-1:0] addr);
        return addr < ADDR_WIDTH'(MEM_WORDS);
    endfunction

    // New bytes where the enable is set, old bytes elsewhere
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                          input logic [DATA_WIDTH-1:0] new_word,
                                                          input logic [BE_WIDTH-1:0] be);
        logic [DATA_WIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < BE_WIDTH; b++)
        begin
            if (be[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic idle_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Holds the write on the bus until the DUT takes it, then drops the strobe
    task automatic issue_write(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [DATA_WIDTH-1:0] data,
                               input logic [BE_WIDTH-1:0] be);
        int waited;
        waited = 0;
        wr_issued++;
        host_wr_write = 1'b1;
        host_wr_req.address = addr;
        host_wr_req.writedata = data;
        host_wr_req.byteenable = be;
        @(negedge clk);
        while (host_wr_waitrequest && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            waited++;
        end
        assert (!host_wr_waitrequest)
        else
        begin
            proto_errors++;
            $display("Timeout at %0t: write to address %0d was never accepted", $time, addr);
        end
        idle_cycle();
        host_wr_write = 1'b0;
    endtask

    task automatic issue_read(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [BE_WIDTH-1:0] be);
        int waited;
        waited = 0;
        rd_issued++;
        host_rd_read = 1'b1;
        host_rd_req.address = addr;
        host_rd_req.byteenable = be;
        @(negedge clk);
        while (host_rd_waitrequest && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            waited++;
        end
        assert (!host_rd_waitrequest)
        else
        begin
            proto_errors++;
            $display("Timeout at %0t: read of address %0d was never accepted", $time, addr);
        end
        idle_cycle();
        host_rd_read = 1'b0;
    endtask

    // The response monitor pops on the falling edge, so poll on the rising one
    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_rd_data.size() != 0 || exp_wr_resp.size() != 0) && waited < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            waited++;
        end
        assert (exp_rd_data.size() == 0 && exp_wr_resp.size() == 0)
        else
        begin
            proto_errors++;
            $display("Timeout at %0t: %0d read and %0d write responses never arrived",
                     $time, exp_rd_data.size(), exp_wr_resp.size());
        end
        idle_cycle();
    endtask

    task automatic write_expect(input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] data,
                                input logic [BE_WIDTH-1:0] be);
        if (addr_in_range(addr))
        begin
            exp_wr_resp.push_back(RESP_OKAY);
            shadow[addr[MEM_IDX_WIDTH-1:0]] = merge_bytes(shadow[addr[MEM_IDX_WIDTH-1:0]],
                                                          data, be);
        end
        else
        begin
            // Out of range writes leave every word alone
            exp_wr_resp.push_back(RESP_SLVERR);
        end
        issue_write(addr, data, be);
    endtask

    task automatic read_expect(input logic [ADDR_WIDTH-1:0] addr);
        if (addr_in_range(addr))
        begin
            exp_rd_data.push_back(shadow[addr[MEM_IDX_WIDTH-1:0]]);
            exp_rd_resp.push_back(RESP_OKAY);
        end
        else
        begin
            exp_rd_data.push_back('0);
            exp_rd_resp.push_back(RESP_SLVERR);
        end
        issue_read(addr, 4'hf);
    endtask

    task automatic load_table();
        dir_table[0]  = '{1'b1, 10'd5,    32'h11223344, 4'hf, 32'h00000000, RESP_OKAY};
        dir_table[1]  = '{1'b0, 10'd5,    32'h00000000, 4'hf, 32'h11223344, RESP_OKAY};
        // Bytes 0 and 2 replaced, bytes 1 and 3 kept
        dir_table[2]  = '{1'b1, 10'd5,    32'haabbccdd, 4'h5, 32'h00000000, RESP_OKAY};
        dir_table[3]  = '{1'b0, 10'd5,    32'h00000000, 4'hf, 32'h11bb33dd, RESP_OKAY};
        dir_table[4]  = '{1'b1, 10'd6,    32'hcafef00d, 4'hf, 32'h00000000, RESP_OKAY};
        dir_table[5]  = '{1'b1, 10'd6,    32'h12345678, 4'ha, 32'h00000000, RESP_OKAY};
        dir_table[6]  = '{1'b0, 10'd6,    32'h00000000, 4'hf, 32'h12fe560d, RESP_OKAY};
        dir_table[7]  = '{1'b1, 10'd44,   32'h0badf00d, 4'hf, 32'h00000000, RESP_OKAY};
        // 300 and 256 share their low address bits with 44 and 0
        dir_table[8]  = '{1'b1, 10'd300,  32'hdeadbeef, 4'hf, 32'h00000000, RESP_SLVERR};
        dir_table[9]  = '{1'b0, 10'd300,  32'h00000000, 4'hf, 32'h00000000, RESP_SLVERR};
        dir_table[10] = '{1'b0, 10'd1023, 32'h00000000, 4'hf, 32'h00000000, RESP_SLVERR};
        dir_table[11] = '{1'b0, 10'd44,   32'h00000000, 4'hf, 32'h0badf00d, RESP_OKAY};
        dir_table[12] = '{1'b1, 10'd0,    32'ha5a5a5a5, 4'hf, 32'h00000000, RESP_OKAY};
        dir_table[13] = '{1'b1, 10'd256,  32'hffffffff, 4'hf, 32'h00000000, RESP_SLVERR};
        dir_table[14] = '{1'b0, 10'd0,    32'h00000000, 4'hf, 32'ha5a5a5a5, RESP_OKAY};
    endtask

    task automatic apply_entry(input dir_entry_t e);
        if (e.is_write)
        begin
            exp_wr_resp.push_back(e.exp_resp);
            if (addr_in_range(e.addr))
            begin
                shadow[e.addr[MEM_IDX_WIDTH-1:0]] =
                    merge_bytes(shadow[e.addr[MEM_IDX_WIDTH-1:0]], e.data, e.be);
            end
            issue_write(e.addr, e.data, e.be);
        end
        else
        begin
            exp_rd_data.push_back(e.exp_data);
            exp_rd_resp.push_back(e.exp_resp);
            issue_read(e.addr, e.be);
        end
        wait_drain();
    endtask

    // Both strobes rise together, the write reaches memory first, so the read sees new data
    task automatic collide_same_addr(input logic [ADDR_WIDTH-1:0] addr,
                                     input logic [DATA_WIDTH-1:0] data);
        shadow[addr[MEM_IDX_WIDTH-1:0]] = data;
        exp_wr_resp.push_back(RESP_OKAY);
        exp_rd_data.push_back(data);
        exp_rd_resp.push_back(RESP_OKAY);
        fork
            issue_write(addr, data, 4'hf);
            issue_read(addr, 4'hf);
        join
        wait_drain();
    endtask

    // Writes hit one bank while reads hit the other, so read data never depends on arbitration
    task automatic run_round(input int round);
        logic [31:0]           r;
        int                    wr_base;
        int                    rd_base;
        logic [ADDR_WIDTH-1:0] wa [ROUND_LEN];
        logic [ADDR_WIDTH-1:0] ra [ROUND_LEN];
        logic [DATA_WIDTH-1:0] wd [ROUND_LEN];
        logic [BE_WIDTH-1:0]   wbe [ROUND_LEN];
        logic                  wgap [ROUND_LEN];
        logic                  rgap [ROUND_LEN];
        wr_base = (round % 2) * BANK_WORDS;
        rd_base = BANK_WORDS - wr_base;
        for (int i = 0; i < ROUND_LEN; i++)
        begin
            r = $random(seed);
            wa[i] = ADDR_WIDTH'(wr_base + int'(r[3:0]));
            ra[i] = ADDR_WIDTH'(rd_base + int'(r[7:4]));
            if (r[10:8] == 3'd0)
            begin
                wa[i] = ADDR_WIDTH'(MEM_WORDS + int'(r[3:0]));
            end
            if (r[13:11] == 3'd0)
            begin
                ra[i] = ADDR_WIDTH'(MEM_WORDS + 64 + int'(r[7:4]));
            end
            wbe[i] = r[17:14];
            wgap[i] = (r[19:18] == 2'd0);
            rgap[i] = (r[21:20] == 2'd0);
            wd[i] = $random(seed);
        end
        fork
            begin
                for (int i = 0; i < ROUND_LEN; i++)
                begin
                    if (wgap[i])
                    begin
                        idle_cycle();
                    end
                    write_expect(wa[i], wd[i], wbe[i]);
                end
            end
            begin
                for (int i = 0; i < ROUND_LEN; i++)
                begin
                    if (rgap[i])
                    begin
                        idle_cycle();
                    end
                    read_expect(ra[i]);
                end
            end
        join
        wait_drain();
    endtask

    // Counts handshakes and checks every response against the queues
    always @(negedge clk)
    begin
        if (!reset)
        begin
            if (host_rd_read && !host_rd_waitrequest)
            begin
                rd_accepted++;
            end
            if (host_wr_write && !host_wr_waitrequest)
            begin
                wr_accepted++;
            end
            if (host_rd_readdatavalid)
            begin
                rd_responses++;
                assert (exp_rd_data.size() != 0)
                else
                begin
                    resp_errors++;
                    $display("Error at %0t: read response with no read outstanding", $time);
                end
                if (exp_rd_data.size() != 0)
                begin
                    want_data = exp_rd_data.pop_front();
                    want_resp = exp_rd_resp.pop_front();
                    assert (host_rd_rsp.readdata == want_data)
                    else
                    begin
                        data_errors++;
                        $display("Fail at %0t: host_rd_rsp.readdata = %h, expected %h",
                                 $time, host_rd_rsp.readdata, want_data);
                    end
                    assert (host_rd_rsp.response == want_resp)
                    else
                    begin
                        resp_errors++;
                        $display("Fail at %0t: host_rd_rsp.response = %0d, expected %0d",
                                 $time, host_rd_rsp.response, want_resp);
                    end
                end
            end
            if (host_wr_writeresponsevalid)
            begin
                wr_responses++;
                assert (exp_wr_resp.size() != 0)
                else
                begin
                    resp_errors++;
                    $display("Error at %0t: write response with no write outstanding", $time);
                end
                if (exp_wr_resp.size() != 0)
                begin
                    want_resp = exp_wr_resp.pop_front();
                    assert (host_wr_rsp.response == want_resp)
                    else
                    begin
                        resp_errors++;
                        $display("Fail at %0t: host_wr_rsp.response = %0d, expected %0d",
                                 $time, host_wr_rsp.response, want_resp);
                    end
                end
            end
        end
    end

    initial
    begin
        reset = 1'b1;
        host_rd_read = 1'b0;
        host_rd_req = '0;
        host_wr_write = 1'b0;
        host_wr_req = '0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        // Quiet bus right after reset
        repeat (3)
        begin
            @(negedge clk);
            assert (!host_rd_waitrequest && !host_wr_waitrequest)
            else
            begin
                proto_errors++;
                $display("Error at %0t: host waitrequest high after reset", $time);
            end
            assert (!host_rd_readdatavalid && !host_wr_writeresponsevalid)
            else
            begin
                proto_errors++;
                $display("Error at %0t: response valid high before any request", $time);
            end
        end
        idle_cycle();

        for (int i = 0; i < N_DIR; i++)
        begin
            apply_entry(dir_table[i]);
        end

        collide_same_addr(10'd6, 32'h5a5ac3c3);

        // Fill both banks, then read them back without waiting between reads
        for (int a = 0; a < 2 * BANK_WORDS; a++)
        begin
            write_expect(ADDR_WIDTH'(a), $random(seed), 4'hf);
        end
        wait_drain();
        for (int a = 0; a < 2 * BANK_WORDS; a++)
        begin
            read_expect(ADDR_WIDTH'(a));
        end
        wait_drain();

        for (int n = 0; n < N_ROUNDS; n++)
        begin
            run_round(n);
        end

        assert (rd_accepted == rd_issued && rd_responses == rd_accepted)
        else
        begin
            proto_errors++;
            $display("Read channel: %0d issued, %0d accepted, %0d responses",
                     rd_issued, rd_accepted, rd_responses);
        end
        assert (wr_accepted == wr_issued && wr_responses == wr_accepted)
        else
        begin
            proto_errors++;
            $display("Write channel: %0d issued, %0d accepted, %0d responses",
                     wr_issued, wr_accepted, wr_responses);
        end

        $display("Errors: data %0d, response %0d, protocol %0d",
                 data_errors, resp_errors, proto_errors);
        if (data_errors + resp_errors + proto_errors == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/avmm_rdwr_pkg.sv
hdl/avmm_wait_bridge.sv
hdl/avmm_rdwr_reg.sv
hdl/avmm_rdwr_mem.sv
hdl/avmm_rdwr_mem_top.sv
sim/avmm_rdwr_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= avmm_rdwr_mem_tb
FILELIST ?= verilog.f
BUILD_DIR ?= ./obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Simulation passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
